// File: Makefile
# Verilator build and run of the vcache_blocking testbench

SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := vcache_tb
FILELIST  := vcache_blocking.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+100

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: design/blocking_cache.sv
//==========================================================================
// blocking_cache: direct-mapped write-back cache, one request at a time,
// with eviction and refill over the DMA channel
//==========================================================================
`timescale 1ns/1ns

module blocking_cache (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  cache_v_i,
  output logic                                  cache_ready_o,
  input  vcache_pkg::cache_op_e                 cache_op_i,
  input  logic [vcache_pkg::addr_width-1:0]     cache_addr_i,
  input  logic [vcache_pkg::data_width-1:0]     cache_data_i,
  output logic                                  cache_rsp_v_o,
  output logic [vcache_pkg::data_width-1:0]     cache_rsp_data_o,
  input  logic                                  cache_rsp_yumi_i,
  output logic                                  v_we_o,

  output logic                                  dma_pkt_v_o,
  output logic                                  dma_pkt_write_o,
  output logic [vcache_pkg::dma_addr_width-1:0] dma_pkt_addr_o,
  input  logic                                  dma_pkt_yumi_i,
  input  logic                                  dma_data_in_v_i,
  input  logic [vcache_pkg::data_width-1:0]     dma_data_in_i,
  output logic                                  dma_data_in_ready_o,
  output logic                                  dma_data_out_v_o,
  output logic [vcache_pkg::data_width-1:0]     dma_data_out_o,
  input  logic                                  dma_data_out_yumi_i
);

  logic [vcache_pkg::tag_width-1:0] tag_mem [vcache_pkg::sets];
  logic [vcache_pkg::data_width-1:0] data_mem [vcache_pkg::sets * vcache_pkg::block_words];
  logic [vcache_pkg::sets-1:0] valid_r, dirty_r;

  vcache_pkg::cache_state_e state_r, state_n;
  vcache_pkg::cache_op_e op_r;
  logic [vcache_pkg::addr_width-1:0] addr_r;
  logic [vcache_pkg::data_width-1:0] data_r;
  logic [vcache_pkg::block_offset_width-1:0] cnt_r;

  logic [vcache_pkg::tag_width-1:0] tag;
  logic [vcache_pkg::index_width-1:0] idx;
  logic [vcache_pkg::block_offset_width-1:0] off;
  logic hit, cnt_last, fill_take, evict_take;

  assign {tag, idx, off} = addr_r;
  assign hit = valid_r[idx] && (tag_mem[idx] == tag);
  assign cnt_last = &cnt_r;  // fourth word of the line
  assign fill_take = dma_data_in_v_i && dma_data_in_ready_o;
  assign evict_take = dma_data_out_v_o && dma_data_out_yumi_i;

  assign cache_ready_o = (state_r == vcache_pkg::IDLE);
  assign cache_rsp_v_o = (state_r == vcache_pkg::RESPOND) && (op_r == vcache_pkg::CACHE_LW);
  assign cache_rsp_data_o = data_mem[{idx, off}];
  assign v_we_o = (state_r == vcache_pkg::RESPOND) && (op_r == vcache_pkg::CACHE_SW);

  assign dma_pkt_v_o = (state_r == vcache_pkg::EVICT_PKT) || (state_r == vcache_pkg::FILL_PKT);
  assign dma_pkt_write_o = (state_r == vcache_pkg::EVICT_PKT);
  // evictions go to the old tag, refills to the requested one
  assign dma_pkt_addr_o = {dma_pkt_write_o ? tag_mem[idx] : tag, idx,
                           {vcache_pkg::block_offset_width{1'b0}}};
  assign dma_data_in_ready_o = (state_r == vcache_pkg::FILL_DATA);
  assign dma_data_out_v_o = (state_r == vcache_pkg::EVICT_DATA);
  assign dma_data_out_o = data_mem[{idx, cnt_r}];

  always_comb begin
    state_n = state_r;
    case (state_r)
      vcache_pkg::IDLE:
        if (cache_v_i) state_n = vcache_pkg::LOOKUP;
      vcache_pkg::LOOKUP:
        if (hit)
          state_n = vcache_pkg::RESPOND;
        else if (valid_r[idx] && dirty_r[idx])
          state_n = vcache_pkg::EVICT_PKT;
        else
          state_n = vcache_pkg::FILL_PKT;
      vcache_pkg::EVICT_PKT:
        if (dma_pkt_yumi_i) state_n = vcache_pkg::EVICT_DATA;
      vcache_pkg::EVICT_DATA:
        if (evict_take && cnt_last) state_n = vcache_pkg::FILL_PKT;
      vcache_pkg::FILL_PKT:
        if (dma_pkt_yumi_i) state_n = vcache_pkg::FILL_DATA;
      vcache_pkg::FILL_DATA:
        if (fill_take && cnt_last) state_n = vcache_pkg::RESPOND;
      vcache_pkg::RESPOND:
        if (v_we_o || cache_rsp_yumi_i) state_n = vcache_pkg::IDLE;
      default:
        state_n = vcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= vcache_pkg::IDLE;
      valid_r <= '0;
      dirty_r <= '0;
      cnt_r <= '0;
    end else begin
      state_r <= state_n;
      if (evict_take || fill_take)
        cnt_r <= cnt_r + 1'b1;  // wraps back to zero after each line
      if (fill_take && cnt_last) begin
        valid_r[idx] <= 1'b1;
        dirty_r[idx] <= 1'b0;
      end
      if (v_we_o)
        dirty_r[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_ready_o && cache_v_i) begin
      op_r <= cache_op_i;
      addr_r <= cache_addr_i;
      data_r <= cache_data_i;
    end
    if (fill_take) begin
      data_mem[{idx, cnt_r}] <= dma_data_in_i;
      if (cnt_last)
        tag_mem[idx] <= tag;
    end
    if (v_we_o)
      data_mem[{idx, off}] <= data_r;
  end

endmodule

// File: design/dma_wb_master.sv
//==========================================================================
// dma_wb_master: runs DMA line packets as Wishbone classic word cycles
//==========================================================================
`timescale 1ns/1ns

module dma_wb_master (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  input  logic                                  dma_pkt_v_i,
  input  logic                                  dma_pkt_write_i,
  input  logic [vcache_pkg::dma_addr_width-1:0] dma_pkt_addr_i,
  output logic                                  dma_pkt_yumi_o,
  output logic                                  dma_data_in_v_o,
  output logic [vcache_pkg::data_width-1:0]     dma_data_in_o,
  input  logic                                  dma_data_in_ready_i,
  input  logic                                  dma_data_out_v_i,
  input  logic [vcache_pkg::data_width-1:0]     dma_data_out_i,
  output logic                                  dma_data_out_yumi_o,

  output logic                                  wb_cyc_o,
  output logic                                  wb_stb_o,
  output logic                                  wb_we_o,
  output logic [vcache_pkg::addr_width-1:0]     wb_adr_o,
  output logic [vcache_pkg::data_width-1:0]     wb_dat_o,
  input  logic [vcache_pkg::data_width-1:0]     wb_dat_i,
  input  logic                                  wb_ack_i
);

  logic busy_r, stb_r, write_r, we_r, start, done;
  logic [vcache_pkg::block_offset_width-1:0] cnt_r;
  logic [vcache_pkg::dma_addr_width-1:0] base_r;
  logic [vcache_pkg::addr_width-1:0] adr_r;
  logic [vcache_pkg::data_width-1:0] dat_r;

  assign dma_pkt_yumi_o = dma_pkt_v_i & ~busy_r;
  // a word starts only when its data source or sink is there, and stb was low a cycle
  assign start = busy_r & ~stb_r & (write_r ? dma_data_out_v_i : dma_data_in_ready_i);
  assign done = stb_r & wb_ack_i;

  assign dma_data_out_yumi_o = start & write_r;
  assign dma_data_in_v_o = done & ~we_r;
  assign dma_data_in_o = wb_dat_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      stb_r <= 1'b0;
      cnt_r <= '0;
    end else begin
      if (dma_pkt_yumi_o)
        busy_r <= 1'b1;
      else if (done && (&cnt_r))
        busy_r <= 1'b0;
      if (start)
        stb_r <= 1'b1;
      else if (done)
        stb_r <= 1'b0;
      if (done)
        cnt_r <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dma_pkt_yumi_o) begin
      write_r <= dma_pkt_write_i;
      base_r <= dma_pkt_addr_i;
    end
    if (start) begin
      we_r <= write_r;
      adr_r <= {base_r[vcache_pkg::dma_addr_width-1:vcache_pkg::block_offset_width], cnt_r};
      dat_r <= dma_data_out_i;
    end
  end

  assign wb_cyc_o = stb_r;  // one classic cycle per word
  assign wb_stb_o = stb_r;
  assign wb_we_o = we_r;
  assign wb_adr_o = adr_r;
  assign wb_dat_o = dat_r;

endmodule

// File: design/link_to_cache.sv
//==========================================================================
// link_to_cache: turns network requests into cache operations and returns
// one tagged response per request
//==========================================================================
`timescale 1ns/1ns

module link_to_cache (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic                                req_v_i,
  output logic                                req_ready_o,
  input  vcache_pkg::net_op_e                 req_op_i,
  input  logic [vcache_pkg::addr_width-1:0]   req_addr_i,
  input  logic [vcache_pkg::data_width-1:0]   req_data_i,
  input  logic [vcache_pkg::id_width-1:0]     req_id_i,
  output logic                                rsp_v_o,
  output logic [vcache_pkg::data_width-1:0]   rsp_data_o,
  output logic [vcache_pkg::id_width-1:0]     rsp_id_o,
  output logic                                rsp_is_store_o,
  input  logic                                rsp_yumi_i,

  output logic                                cache_v_o,
  input  logic                                cache_ready_i,
  output vcache_pkg::cache_op_e               cache_op_o,
  output logic [vcache_pkg::addr_width-1:0]   cache_addr_o,
  output logic [vcache_pkg::data_width-1:0]   cache_data_o,
  input  logic                                cache_rsp_v_i,
  input  logic [vcache_pkg::data_width-1:0]   cache_rsp_data_i,
  output logic                                cache_rsp_yumi_o,
  input  logic                                v_we_i
);

  logic ready_r, busy_r, accept;
  logic cache_v_r, rsp_v_r, is_store_r;
  vcache_pkg::cache_op_e cache_op_r;
  logic [vcache_pkg::addr_width-1:0] cache_addr_r;
  logic [vcache_pkg::data_width-1:0] cache_data_r, rsp_data_r;
  logic [vcache_pkg::id_width-1:0] id_r;

  assign accept = req_v_i & ready_r;
  assign cache_rsp_yumi_o = cache_rsp_v_i & ~rsp_v_r;  // held off while a response waits

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_r <= 1'b0;
      busy_r <= 1'b0;
      cache_v_r <= 1'b0;
      rsp_v_r <= 1'b0;
    end else begin
      if (accept) begin
        ready_r <= 1'b0;
        busy_r <= 1'b1;
      end else if (rsp_yumi_i) begin
        ready_r <= 1'b1;
        busy_r <= 1'b0;
      end else if (!busy_r) begin
        ready_r <= 1'b1;  // first opening after reset
      end
      if (accept)
        cache_v_r <= 1'b1;
      else if (cache_ready_i)
        cache_v_r <= 1'b0;
      if (cache_rsp_yumi_o || v_we_i)
        rsp_v_r <= 1'b1;
      else if (rsp_yumi_i)
        rsp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cache_op_r <= (req_op_i == vcache_pkg::NET_STORE) ? vcache_pkg::CACHE_SW
                                                        : vcache_pkg::CACHE_LW;
      is_store_r <= (req_op_i == vcache_pkg::NET_STORE);
      cache_addr_r <= req_addr_i;
      cache_data_r <= req_data_i;
      id_r <= req_id_i;
    end
    if (cache_rsp_yumi_o)
      rsp_data_r <= cache_rsp_data_i;
    else if (v_we_i)
      rsp_data_r <= '0;  // store acknowledgement carries no data
  end

  assign req_ready_o = ready_r;
  assign cache_v_o = cache_v_r;
  assign cache_op_o = cache_op_r;
  assign cache_addr_o = cache_addr_r;
  assign cache_data_o = cache_data_r;
  assign rsp_v_o = rsp_v_r;
  assign rsp_data_o = rsp_data_r;
  assign rsp_id_o = id_r;
  assign rsp_is_store_o = is_store_r;

endmodule

// File: design/vcache_blocking.sv
//==========================================================================
// vcache_blocking: network adapter, blocking cache and Wishbone DMA bridge
//==========================================================================
`timescale 1ns/1ns

module vcache_blocking (
  input  logic                                clk_i,
  input  logic                                reset_i,

  input  logic                                req_v_i,
  output logic                                req_ready_o,
  input  vcache_pkg::net_op_e                 req_op_i,
  input  logic [vcache_pkg::addr_width-1:0]   req_addr_i,
  input  logic [vcache_pkg::data_width-1:0]   req_data_i,
  input  logic [vcache_pkg::id_width-1:0]     req_id_i,
  output logic                                rsp_v_o,
  output logic [vcache_pkg::data_width-1:0]   rsp_data_o,
  output logic [vcache_pkg::id_width-1:0]     rsp_id_o,
  output logic                                rsp_is_store_o,
  input  logic                                rsp_yumi_i,

  output logic                                wb_cyc_o,
  output logic                                wb_stb_o,
  output logic                                wb_we_o,
  output logic [vcache_pkg::addr_width-1:0]   wb_adr_o,
  output logic [vcache_pkg::data_width-1:0]   wb_dat_o,
  input  logic [vcache_pkg::data_width-1:0]   wb_dat_i,
  input  logic                                wb_ack_i
);

  logic reset_r;
  logic cache_v, cache_ready, cache_rsp_v, cache_rsp_yumi, v_we;
  vcache_pkg::cache_op_e cache_op;
  logic [vcache_pkg::addr_width-1:0] cache_addr;
  logic [vcache_pkg::data_width-1:0] cache_data, cache_rsp_data;
  logic dma_pkt_v, dma_pkt_write, dma_pkt_yumi;
  logic [vcache_pkg::dma_addr_width-1:0] dma_pkt_addr;
  logic dma_data_in_v, dma_data_in_ready, dma_data_out_v, dma_data_out_yumi;
  logic [vcache_pkg::data_width-1:0] dma_data_in, dma_data_out;

  always_ff @(posedge clk_i) begin
    reset_r <= reset_i;  // all blocks leave reset one cycle late
  end

  link_to_cache link0 (
    .clk_i(clk_i), .reset_i(reset_r),
    .req_v_i(req_v_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_id_i(req_id_i),
    .rsp_v_o(rsp_v_o), .rsp_data_o(rsp_data_o), .rsp_id_o(rsp_id_o),
    .rsp_is_store_o(rsp_is_store_o), .rsp_yumi_i(rsp_yumi_i),
    .cache_v_o(cache_v), .cache_ready_i(cache_ready), .cache_op_o(cache_op),
    .cache_addr_o(cache_addr), .cache_data_o(cache_data),
    .cache_rsp_v_i(cache_rsp_v), .cache_rsp_data_i(cache_rsp_data),
    .cache_rsp_yumi_o(cache_rsp_yumi), .v_we_i(v_we)
  );

  blocking_cache cache0 (
    .clk_i(clk_i), .reset_i(reset_r),
    .cache_v_i(cache_v), .cache_ready_o(cache_ready), .cache_op_i(cache_op),
    .cache_addr_i(cache_addr), .cache_data_i(cache_data),
    .cache_rsp_v_o(cache_rsp_v), .cache_rsp_data_o(cache_rsp_data),
    .cache_rsp_yumi_i(cache_rsp_yumi), .v_we_o(v_we),
    .dma_pkt_v_o(dma_pkt_v), .dma_pkt_write_o(dma_pkt_write),
    .dma_pkt_addr_o(dma_pkt_addr), .dma_pkt_yumi_i(dma_pkt_yumi),
    .dma_data_in_v_i(dma_data_in_v), .dma_data_in_i(dma_data_in),
    .dma_data_in_ready_o(dma_data_in_ready),
    .dma_data_out_v_o(dma_data_out_v), .dma_data_out_o(dma_data_out),
    .dma_data_out_yumi_i(dma_data_out_yumi)
  );

  dma_wb_master dma0 (
    .clk_i(clk_i), .reset_i(reset_r),
    .dma_pkt_v_i(dma_pkt_v), .dma_pkt_write_i(dma_pkt_write),
    .dma_pkt_addr_i(dma_pkt_addr), .dma_pkt_yumi_o(dma_pkt_yumi),
    .dma_data_in_v_o(dma_data_in_v), .dma_data_in_o(dma_data_in),
    .dma_data_in_ready_i(dma_data_in_ready),
    .dma_data_out_v_i(dma_data_out_v), .dma_data_out_i(dma_data_out),
    .dma_data_out_yumi_o(dma_data_out_yumi),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
    .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o),
    .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
  );

endmodule

// File: design/vcache_pkg.sv
//==========================================================================
// vcache package: sizes, address fields and the opcode and state encodings
//==========================================================================
package vcache_pkg;

  localparam int data_width = 32;
  localparam int addr_width = 12;  // word address on the network side

  localparam int block_words = 4;
  localparam int block_offset_width = $clog2(block_words);

  localparam int sets = 16;
  localparam int index_width = $clog2(sets);

  localparam int tag_width = addr_width - index_width - block_offset_width;

  localparam int id_width = 4;

  // line-aligned word address carried by a DMA packet
  localparam int dma_addr_width = addr_width;

  typedef enum logic {
    NET_LOAD,
    NET_STORE
  } net_op_e;

  typedef enum logic {
    CACHE_LW,
    CACHE_SW
  } cache_op_e;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT_PKT,
    EVICT_DATA,
    FILL_PKT,
    FILL_DATA,
    RESPOND
  } cache_state_e;

endpackage

// File: tests/tb_clock.sv
//==========================================================================
// testbench clock source, 100 ns period
//==========================================================================
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o
);

  localparam int half_period = 50;

  initial begin
    clk_o = 1'b0;
    forever #half_period clk_o = ~clk_o;
  end

endmodule

// File: tests/vcache_properties.sv
//==========================================================================
// handshake assertions for the network response and Wishbone ports
//==========================================================================
`timescale 1ns/1ns

module vcache_properties (
  input logic                              clk_i,
  input logic                              reset_i,
  input logic                              rsp_v_o,
  input logic                              rsp_yumi_i,
  input logic [vcache_pkg::data_width-1:0] rsp_data_o,
  input logic [vcache_pkg::id_width-1:0]   rsp_id_o,
  input logic                              rsp_is_store_o,
  input logic                              wb_cyc_o,
  input logic                              wb_stb_o,
  input logic                              wb_ack_i
);

  int yumi_fails = 0;
  int stb_fails = 0;
  int hold_fails = 0;

  yumi_with_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_yumi_i |-> rsp_v_o)
    else begin
      yumi_fails++;
      $error("rsp_yumi_i high without rsp_v_o");
    end

  // each word is its own classic cycle, so cyc and stb both fall after the ack
  cycle_ends_on_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_stb_o && wb_ack_i |=> !wb_stb_o && !wb_cyc_o)
    else begin
      stb_fails++;
      $error("Wishbone cycle still open after its ack");
    end

  // a waiting response may not change until it is taken
  rsp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_v_o && !rsp_yumi_i |=> rsp_v_o && $stable(rsp_data_o) && $stable(rsp_id_o)
                               && $stable(rsp_is_store_o))
    else begin
      hold_fails++;
      $error("response changed before rsp_yumi_i");
    end

endmodule

// File: tests/vcache_tb.sv
//==========================================================================
// vcache testbench: Wishbone memory model, shadow memory and a request
// table checked against the shadow
//==========================================================================
`timescale 1ns/1ns

module vcache_tb;

  localparam int wait_limit = 200;
  localparam int mem_words = 1 << vcache_pkg::addr_width;
  localparam logic [31:0] fill_pattern = 32'ha5a50000;

  logic clk_i, reset_i;
  logic req_v_i, req_ready_o, rsp_v_o, rsp_is_store_o, rsp_yumi_i;
  vcache_pkg::net_op_e req_op_i;
  logic [vcache_pkg::addr_width-1:0] req_addr_i;
  logic [vcache_pkg::data_width-1:0] req_data_i, rsp_data_o;
  logic [vcache_pkg::id_width-1:0] req_id_i, rsp_id_o;
  logic wb_cyc_o, wb_stb_o, wb_we_o, wb_ack_i;
  logic [vcache_pkg::addr_width-1:0] wb_adr_o;
  logic [vcache_pkg::data_width-1:0] wb_dat_o, wb_dat_i;

  logic [31:0] mem [mem_words];
  logic [31:0] shadow [mem_words];
  integer seed;
  int wb_wait, tests_passed, tests_failed, errors;
  bit wb_pending, timed_out;

  string name_q[$];
  vcache_pkg::net_op_e op_q[$];
  logic [11:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [3:0] id_q[$];
  int delay_q[$];
  bit hit_q[$];

  tb_clock clock0 (.clk_o(clk_i));

  vcache_blocking dut0 (
    .clk_i(clk_i), .reset_i(reset_i),
    .req_v_i(req_v_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
    .req_addr_i(req_addr_i), .req_data_i(req_data_i), .req_id_i(req_id_i),
    .rsp_v_o(rsp_v_o), .rsp_data_o(rsp_data_o), .rsp_id_o(rsp_id_o),
    .rsp_is_store_o(rsp_is_store_o), .rsp_yumi_i(rsp_yumi_i),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o),
    .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
  );

  bind vcache_blocking vcache_properties props0 (
    .clk_i(clk_i), .reset_i(reset_i), .rsp_v_o(rsp_v_o), .rsp_yumi_i(rsp_yumi_i),
    .rsp_data_o(rsp_data_o), .rsp_id_o(rsp_id_o), .rsp_is_store_o(rsp_is_store_o),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_ack_i(wb_ack_i)
  );

  // Wishbone slave memory, acks each word after 0 to 2 extra cycles
  initial begin
    wb_ack_i <= 1'b0;
    wb_dat_i <= '0;
    seed = 32'h58e3;
    wb_pending = 1'b0;
    for (int a = 0; a < mem_words; a++)
      mem[a[11:0]] = 32'(a) ^ fill_pattern;
    forever begin
      @(posedge clk_i);
      if (reset_i) begin
        wb_ack_i <= 1'b0;
        wb_pending = 1'b0;
      end else if (wb_ack_i) begin
        wb_ack_i <= 1'b0;  // ack lasts one cycle, the bridge drops stb with it
      end else if (wb_cyc_o && wb_stb_o) begin
        if (!wb_pending) begin
          wb_pending = 1'b1;
          wb_wait = {$random(seed)} % 3;
        end
        if (wb_wait == 0) begin
          wb_pending = 1'b0;
          wb_ack_i <= 1'b1;
          if (wb_we_o)
            mem[wb_adr_o] = wb_dat_o;
          else
            wb_dat_i <= mem[wb_adr_o];
        end else begin
          wb_wait = wb_wait - 1;
        end
      end
    end
  end

  task automatic add_test(input string name, input vcache_pkg::net_op_e op,
                          input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] id, input int delay, input bit hit);
    name_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    data_q.push_back(data);
    id_q.push_back(id);
    delay_q.push_back(delay);
    hit_q.push_back(hit);
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    errors++;
    $display("** Error %0s: %0s expected %h actual %h", name, what, expected, actual);
  endtask

  task automatic report_failure(input string name, input string what);
    errors++;
    $display("** Error %0s: %0s", name, what);
  endtask

  task automatic close_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("test %0s: pass", name);
    end else begin
      tests_failed++;
      $display("test %0s: failed", name);
    end
  endtask

  task automatic check_reset();
    int cycles;
    int errors_before;
    bit seen;
    errors_before = errors;
    repeat (3) @(posedge clk_i);
    if (req_ready_o !== 1'b0) report_failure("reset", "req_ready_o high during reset");
    if (rsp_v_o !== 1'b0) report_failure("reset", "rsp_v_o high during reset");
    if (wb_cyc_o !== 1'b0) report_failure("reset", "wb_cyc_o high during reset");
    reset_i <= 1'b0;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < 20) begin
      @(posedge clk_i);
      cycles++;
      seen = (req_ready_o === 1'b1);
      if (wb_cyc_o !== 1'b0) report_failure("reset", "wb_cyc_o high with no request");
    end
    if (!seen) begin
      report_failure("reset", "req_ready_o never rose after reset");
      timed_out = 1'b1;
    end
    close_test("reset", errors_before);
  endtask

  task automatic run_test(input int i);
    int cycles;
    int errors_before;
    bit seen, store;
    logic [31:0] expected;
    string name;
    name = name_q[i];
    errors_before = errors;
    store = (op_q[i] == vcache_pkg::NET_STORE);
    if (store) begin
      expected = '0;
      shadow[addr_q[i]] = data_q[i];
    end else begin
      expected = shadow[addr_q[i]];
    end
    req_v_i <= 1'b1;
    req_op_i <= op_q[i];
    req_addr_i <= addr_q[i];
    req_data_i <= data_q[i];
    req_id_i <= id_q[i];
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < wait_limit) begin
      @(posedge clk_i);
      cycles++;
      seen = (req_ready_o === 1'b1);
    end
    req_v_i <= 1'b0;
    if (!seen) begin
      report_failure(name, "request was not accepted in time");
      timed_out = 1'b1;
      close_test(name, errors_before);
      return;
    end
    cycles = 0;  // counts edges from the handshake
    seen = 1'b0;
    while (!seen && cycles < wait_limit) begin
      @(posedge clk_i);
      cycles++;
      seen = (rsp_v_o === 1'b1);
      if (!seen && req_ready_o !== 1'b0) report_failure(name, "req_ready_o high in flight");
    end
    if (!seen) begin
      report_failure(name, "no response arrived in time");
      timed_out = 1'b1;
      close_test(name, errors_before);
      return;
    end
    if (hit_q[i] && cycles != 4) report_mismatch(name, "hit latency", 32'd4, 32'(cycles));
    if (rsp_id_o !== id_q[i]) report_mismatch(name, "rsp_id_o", 32'(id_q[i]), 32'(rsp_id_o));
    if (rsp_is_store_o !== store)
      report_mismatch(name, "rsp_is_store_o", 32'(store), 32'(rsp_is_store_o));
    if (rsp_data_o !== expected) report_mismatch(name, "rsp_data_o", expected, rsp_data_o);
    repeat (delay_q[i]) begin
      @(posedge clk_i);
      if (rsp_v_o !== 1'b1) report_failure(name, "rsp_v_o dropped before rsp_yumi_i");
      if (rsp_data_o !== expected)
        report_mismatch(name, "rsp_data_o while held", expected, rsp_data_o);
      if (rsp_id_o !== id_q[i])
        report_mismatch(name, "rsp_id_o while held", 32'(id_q[i]), 32'(rsp_id_o));
      if (req_ready_o !== 1'b0) report_failure(name, "req_ready_o high before rsp_yumi_i");
    end
    rsp_yumi_i <= 1'b1;
    @(posedge clk_i);
    rsp_yumi_i <= 1'b0;
    close_test(name, errors_before);
  endtask

  // evicted dirty lines must have reached the memory model
  task automatic check_writeback();
    logic [11:0] addrs [3];
    int errors_before;
    errors_before = errors;
    addrs = '{12'h012, 12'h3a7, 12'h7a5};
    foreach (addrs[k]) begin
      if (mem[addrs[k]] !== shadow[addrs[k]])
        report_mismatch("writeback", "memory word", shadow[addrs[k]], mem[addrs[k]]);
    end
    close_test("writeback", errors_before);
  endtask

  initial begin
    int assert_fails;
    reset_i <= 1'b1;
    req_v_i <= 1'b0;
    req_op_i <= vcache_pkg::NET_LOAD;
    req_addr_i <= '0;
    req_data_i <= '0;
    req_id_i <= '0;
    rsp_yumi_i <= 1'b0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    for (int a = 0; a < mem_words; a++)
      shadow[a[11:0]] = 32'(a) ^ fill_pattern;

    // name, op, address, data, id, yumi delay, expected hit
    add_test("load_cold", vcache_pkg::NET_LOAD, 12'h010, 32'h0, 4'd1, 0, 1'b0);
    add_test("load_hit", vcache_pkg::NET_LOAD, 12'h011, 32'h0, 4'd2, 0, 1'b1);
    add_test("store_hit", vcache_pkg::NET_STORE, 12'h012, 32'hdeadbeef, 4'd3, 0, 1'b1);
    add_test("load_after_store", vcache_pkg::NET_LOAD, 12'h012, 32'h0, 4'd4, 0, 1'b1);
    add_test("load_conflict", vcache_pkg::NET_LOAD, 12'h052, 32'h0, 4'd5, 1, 1'b0);
    add_test("load_refill", vcache_pkg::NET_LOAD, 12'h012, 32'h0, 4'd6, 0, 1'b0);
    add_test("store_miss_stall", vcache_pkg::NET_STORE, 12'h3a7, 32'h12345678, 4'd7, 5, 1'b0);
    add_test("load_stall", vcache_pkg::NET_LOAD, 12'h3a7, 32'h0, 4'd8, 3, 1'b1);
    add_test("store_evict", vcache_pkg::NET_STORE, 12'h7a5, 32'hcafef00d, 4'd9, 2, 1'b0);
    add_test("load_evicted", vcache_pkg::NET_LOAD, 12'h3a7, 32'h0, 4'd10, 0, 1'b0);
    add_test("load_top", vcache_pkg::NET_LOAD, 12'hfff, 32'h0, 4'd15, 1, 1'b0);
    add_test("load_top_hit", vcache_pkg::NET_LOAD, 12'hffc, 32'h0, 4'd0, 4, 1'b1);
    add_test("load_evicted_2", vcache_pkg::NET_LOAD, 12'h7a5, 32'h0, 4'd11, 0, 1'b0);

    check_reset();
    for (int i = 0; i < name_q.size() && !timed_out; i++)
      run_test(i);
    if (!timed_out)
      check_writeback();

    assert_fails = dut0.props0.yumi_fails + dut0.props0.stb_fails + dut0.props0.hold_fails;
    $display("tests: %0d run, %0d passed, %0d failed, %0d assertion failures",
             tests_passed + tests_failed, tests_passed, tests_failed, assert_fails);
    if (tests_failed == 0 && !timed_out && assert_fails == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: vcache_blocking.f
design/vcache_pkg.sv
design/link_to_cache.sv
design/blocking_cache.sv
design/dma_wb_master.sv
design/vcache_blocking.sv
tests/tb_clock.sv
tests/vcache_properties.sv
tests/vcache_tb.sv
